// ==== testbench/program_input.txt ====
# kind addr aux data (hex): 0 program word, 1 word on a skipped path,
# 2 expected write (aux = wstrb, data masked), 3 address of the faulting load
0 00000000 0 123450b7
0 00000004 0 ffd00113
0 00000008 0 002081b3
0 0000000c 0 20302023
0 00000010 0 40115213
0 00000014 0 0020b2b3
0 00000018 0 00524233
0 0000001c 0 20402223
0 00000020 0 00001317
0 00000024 0 20602423
0 00000028 0 00014463
1 0000002c 0 00100393
0 00000030 0 00010463
0 00000034 0 008003ef
1 00000038 0 00100393
0 0000003c 0 04400467
1 00000040 0 00100393
0 00000044 0 008384b3
0 00000048 0 20902623
0 0000004c 0 202008a3
0 00000050 0 20101b23
0 00000054 0 21100503
0 00000058 0 21605583
0 0000005c 0 00b50633
0 00000060 0 20c02c23
0 00000064 0 20202683
2 00000200 f 12344ffd
2 00000204 f ffffffff
2 00000208 f 00001020
2 0000020c f 00000078
2 00000210 2 0000fd00
2 00000214 c 50000000
2 00000218 f 00004ffd
3 00000064 0 00000000

// ==== filelist.f ====
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_lsu.sv
source/rv_core.sv
testbench/rv_core_assert.sv
testbench/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb \
  -f filelist.f -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" sim.log; then
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// ==== testbench/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;
  import rv_pkg::*;

  localparam string data_file = "testbench/program_input.txt";

  logic clk;
  logic reset;
  mem_req_t mem_req;
  logic mem_ready = 1'b0;
  logic [xlen-1:0] mem_rdata = '0;
  logic trap;

  logic [31:0] mem [256];
  logic not_taken [256];
  logic [31:0] exp_addr [$];
  logic [3:0] exp_strb [$];
  logic [31:0] exp_data [$];
  logic [31:0] trap_addr;
  logic [15:0] lfsr;
  logic loaded;
  logic busy;
  logic first_req;
  logic fault_fetched;
  int prog_words;
  int wait_left;
  int write_idx;
  int bad_fetches;
  int checks;
  int errors;
  int trap_drops;

  rv_core uut (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .trap      (trap)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] strobe_mask(input logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic load_data_file();
    int fd;
    int n;
    string line;
    logic [31:0] kind, addr, aux, data;
    fd = $fopen(data_file, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != 8'h23) begin
          n = $sscanf(line, "%h %h %h %h", kind, addr, aux, data);
          if (n == 4) begin
            case (kind)
              0, 1: begin
                mem[addr[9:2]] = data;
                not_taken[addr[9:2]] = (kind == 1);
                prog_words++;
              end
              2: begin
                exp_addr.push_back(addr);
                exp_strb.push_back(aux[3:0]);
                exp_data.push_back(data);
              end
              default: trap_addr = addr;
            endcase
          end
        end
      end
      $fclose(fd);
      loaded = 1'b1;
    end
  endtask

  // two LFSR bits give 0 to 3 wait states
  task automatic start_request();
    lfsr = lfsr_next(lfsr);
    wait_left = int'(lfsr[0]);
    lfsr = lfsr_next(lfsr);
    wait_left = wait_left * 2 + int'(lfsr[0]);
    if (fault_fetched) begin
      errors++;
      $display("a bus request to %h followed the faulting load", mem_req.addr);
    end
    if (first_req) begin
      first_req = 1'b0;
      checks++;
      if (!mem_req.instr || mem_req.wstrb != 4'b0000 || mem_req.addr != '0) begin
        report_error($sformatf("first request instr %b wstrb %b addr %h, expected fetch at 0",
                               mem_req.instr, mem_req.wstrb, mem_req.addr));
      end else begin
        $display("first fetch: ok");
      end
    end
  endtask

  task automatic serve_request();
    logic [7:0] idx;
    logic [31:0] mask;
    idx = mem_req.addr[9:2];
    mem_rdata <= mem[idx];
    if (mem_req.instr) begin
      if (not_taken[idx]) begin
        bad_fetches++;
        $display("fetch from the skipped path at %h", mem_req.addr);
      end
      if (mem_req.addr == trap_addr) begin
        fault_fetched = 1'b1;
      end
    end else if (mem_req.wstrb != 4'b0000) begin
      mask = strobe_mask(mem_req.wstrb);
      mem[idx] = (mem[idx] & ~mask) | (mem_req.wdata & mask);
      checks++;
      if (write_idx >= exp_addr.size()) begin
        errors++;
        $display("data write to %h beyond the expected list", mem_req.addr);
      end else if (mem_req.addr != exp_addr[write_idx] || mem_req.wstrb != exp_strb[write_idx] ||
                   (mem_req.wdata & mask) != exp_data[write_idx]) begin
        report_error($sformatf("write %0d got %h %b %h, expected %h %b %h", write_idx,
                               mem_req.addr, mem_req.wstrb, mem_req.wdata & mask,
                               exp_addr[write_idx], exp_strb[write_idx], exp_data[write_idx]));
      end else begin
        $display("write %0d to %h: ok", write_idx, mem_req.addr);
      end
      write_idx++;
    end
  endtask

  // memory model, ready is held for exactly one cycle per request
  always @(posedge clk) begin
    if (reset) begin
      mem_ready <= 1'b0;
      busy = 1'b0;
    end else begin
      mem_ready <= 1'b0;
      if (mem_req.valid && !mem_ready) begin
        if (!busy) begin
          busy = 1'b1;
          start_request();
        end
        if (wait_left == 0) begin
          busy = 1'b0;
          mem_ready <= 1'b1;
          serve_request();
        end else begin
          wait_left--;
        end
      end
    end
  end

  initial begin
    wait (loaded);
    #(prog_words * 2000);
    $display("timeout: no trap within %0d cycles", prog_words * 200);
    $display("test failed");
    $finish;
  end

  initial begin
    reset = 1'b1;
    lfsr = 16'd48972;
    loaded = 1'b0;
    busy = 1'b0;
    first_req = 1'b1;
    fault_fetched = 1'b0;
    trap_addr = '1;
    prog_words = 0;
    wait_left = 0;
    write_idx = 0;
    bad_fetches = 0;
    checks = 0;
    errors = 0;
    trap_drops = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = '0;
      not_taken[i] = 1'b0;
    end
    load_data_file();
    if (!loaded) begin
      $display("data file %s could not be opened", data_file);
      $display("test failed");
      $finish;
    end else begin
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      checks++;
      if (trap !== 1'b0 || mem_req.valid !== 1'b0) begin
        report_error($sformatf("after reset trap %b valid %b", trap, mem_req.valid));
      end else begin
        $display("reset: ok");
      end
      while (trap !== 1'b1) begin
        @(posedge clk);
      end
      checks++;
      if (!fault_fetched) begin
        errors++;
        $display("trap rose before the misaligned load at %h was fetched", trap_addr);
      end else begin
        $display("trap after load at %h: ok", trap_addr);
      end
      repeat (20) begin
        @(posedge clk);
        if (trap !== 1'b1) begin
          trap_drops++;
        end
      end
      checks++;
      if (trap_drops != 0) begin
        report_error($sformatf("trap low in %0d cycles after rising", trap_drops));
      end else begin
        $display("trap held: ok");
      end
      checks++;
      if (bad_fetches != 0) begin
        report_error($sformatf("%0d fetches from skipped words", bad_fetches));
      end else begin
        $display("branch paths: ok");
      end
      checks++;
      if (write_idx != exp_addr.size()) begin
        report_error($sformatf("%0d data writes, expected %0d", write_idx, exp_addr.size()));
      end else begin
        $display("write count: ok");
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

// ==== testbench/rv_core_assert.sv ====
`timescale 1ns/1ps

module rv_core_assert (
  input logic             clk,
  input logic             reset,
  input rv_pkg::mem_req_t mem_req,
  input logic             mem_ready,
  input logic             trap
);

  // a waiting request keeps every field
  req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req.valid && !mem_ready |=> $stable(mem_req))
    else $error("bus request changed while waiting for ready");

  fetch_no_strobe: assert property (@(posedge clk) disable iff (reset)
    mem_req.valid && mem_req.instr |-> mem_req.wstrb == 4'b0000)
    else $error("fetch request carries write strobes");

  // only reset may clear trap
  trap_sticky: assert property (@(posedge clk)
    $fell(trap) |-> $past(reset))
    else $error("trap fell without reset");

endmodule

bind rv_core rv_core_assert u_assert (
  .clk       (clk),
  .reset     (reset),
  .mem_req   (mem_req),
  .mem_ready (mem_ready),
  .trap      (trap)
);

// ==== source/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
  input  logic                    clk,
  input  logic                    reset,
  output rv_pkg::mem_req_t        mem_req,
  input  logic                    mem_ready,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,
  output logic                    trap
);
  import rv_pkg::*;

  cpu_state_e state;
  logic [xlen-1:0] pc, next_pc, instr_q, wb_data, target_q;
  decoded_t dec, dec_q;

  logic [xlen-1:0] rs1_data, rs2_data;
  logic [xlen-1:0] alu_b, alu_result;
  logic branch_taken;
  logic [xlen-1:0] pc_plus4, pc_plus_imm, ls_addr, jump_target;
  logic [3:0] lsu_wstrb;
  logic [xlen-1:0] lsu_wdata, load_data;
  logic misaligned;

  assign pc_plus4 = pc + xlen'(4);
  assign pc_plus_imm = pc + dec_q.imm;
  assign ls_addr = rs1_data + dec_q.imm;
  // jalr clears bit 0 of rs1 + imm
  assign jump_target = dec_q.is_jalr ? {ls_addr[xlen-1:1], 1'b0} : pc_plus_imm;
  assign alu_b = dec_q.use_imm ? dec_q.imm : rs2_data;

  rv_decoder u_decoder (
    .instr (instr_q),
    .dec   (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rs1      (dec_q.rs1),
    .rs2      (dec_q.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (state == st_write_back),
    .rd       (dec_q.rd),
    .rd_data  (wb_data)
  );

  rv_alu u_alu (
    .a            (rs1_data),
    .b            (alu_b),
    .alu_op       (dec_q.alu_op),
    .branch_op    (dec_q.branch_op),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  rv_lsu u_lsu (
    .addr        (ls_addr),
    .size        (dec_q.mem_size),
    .is_unsigned (dec_q.load_unsigned),
    .store_data  (rs2_data),
    .mem_rdata   (mem_rdata),
    .wstrb       (lsu_wstrb),
    .wdata       (lsu_wdata),
    .load_data   (load_data),
    .misaligned  (misaligned)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      pc <= '0;
      next_pc <= '0;
      mem_req <= '0;
      trap <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          mem_req.valid <= 1'b1;
          mem_req.instr <= 1'b1;
          mem_req.addr <= next_pc;
          mem_req.wstrb <= 4'b0000;
          state <= st_wait_fetch;
        end
        st_wait_fetch: begin
          if (mem_ready) begin
            mem_req.valid <= 1'b0;
            pc <= mem_req.addr;
            instr_q <= mem_rdata;
            state <= st_decode;
          end
        end
        st_decode: begin
          dec_q <= dec;
          state <= st_execute;
        end
        st_execute: begin
          next_pc <= pc_plus4;
          case (dec_q.op_class)
            cls_lui: begin
              wb_data <= dec_q.imm;
              state <= st_write_back;
            end
            cls_auipc: begin
              wb_data <= pc_plus_imm;
              state <= st_write_back;
            end
            cls_alu: begin
              wb_data <= alu_result;
              state <= st_write_back;
            end
            cls_jump: begin
              wb_data <= pc_plus4;
              target_q <= jump_target;
              state <= st_check_pc;
            end
            cls_branch: begin
              target_q <= branch_taken ? pc_plus_imm : pc_plus4;
              state <= st_check_pc;
            end
            cls_load, cls_store: begin
              if (misaligned) begin
                state <= st_trapped;
              end else begin
                mem_req.valid <= 1'b1;
                mem_req.instr <= 1'b0;
                mem_req.addr <= {ls_addr[xlen-1:2], 2'b00};
                mem_req.wdata <= lsu_wdata;
                if (dec_q.op_class == cls_store) begin
                  mem_req.wstrb <= lsu_wstrb;
                  state <= st_wait_store;
                end else begin
                  mem_req.wstrb <= 4'b0000;
                  state <= st_wait_load;
                end
              end
            end
            default: state <= st_trapped;
          endcase
        end
        st_wait_load: begin
          if (mem_ready) begin
            mem_req.valid <= 1'b0;
            wb_data <= load_data;
            state <= st_write_back;
          end
        end
        st_wait_store: begin
          if (mem_ready) begin
            mem_req.valid <= 1'b0;
            mem_req.wstrb <= 4'b0000;
            state <= st_fetch;
          end
        end
        st_check_pc: begin
          if (target_q[1]) begin
            state <= st_trapped;
          end else begin
            next_pc <= target_q;
            state <= (dec_q.op_class == cls_jump) ? st_write_back : st_fetch;
          end
        end
        st_write_back: state <= st_fetch;
        st_trapped: trap <= 1'b1;
        default: state <= st_trapped;
      endcase
    end
  end

endmodule

// ==== source/rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu (
  input  logic [rv_pkg::xlen-1:0] addr,
  input  rv_pkg::mem_size_e       size,
  input  logic                    is_unsigned,
  input  logic [rv_pkg::xlen-1:0] store_data,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,
  output logic [3:0]              wstrb,
  output logic [rv_pkg::xlen-1:0] wdata,
  output logic [rv_pkg::xlen-1:0] load_data,
  output logic                    misaligned
);
  import rv_pkg::*;

  logic [xlen-1:0] shifted;
  logic [7:0] load_byte;
  logic [15:0] load_half;

  // move the addressed lane down to bit 0
  assign shifted = mem_rdata >> {addr[1:0], 3'b000};
  assign load_byte = shifted[7:0];
  assign load_half = addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    case (size)
      mem_byte: begin
        wstrb = 4'b0001 << addr[1:0];
        wdata = {4{store_data[7:0]}};
        misaligned = 1'b0;
        if (is_unsigned) begin
          load_data = {24'b0, load_byte};
        end else begin
          load_data = {{24{load_byte[7]}}, load_byte};
        end
      end
      mem_half: begin
        wstrb = addr[1] ? 4'b1100 : 4'b0011;
        wdata = {2{store_data[15:0]}};
        misaligned = addr[0];
        if (is_unsigned) begin
          load_data = {16'b0, load_half};
        end else begin
          load_data = {{16{load_half[15]}}, load_half};
        end
      end
      default: begin
        wstrb = 4'b1111;
        wdata = store_data;
        misaligned = (addr[1:0] != 2'b00);
        load_data = mem_rdata;
      end
    endcase
  end

endmodule

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic                          clk,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data,
  input  logic                          we,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic [rv_pkg::xlen-1:0]       rd_data
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [2**reg_addr_w];

  // x0 is never written, reads of it are forced to zero
  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  input  rv_pkg::alu_op_e         alu_op,
  input  rv_pkg::branch_op_e      branch_op,
  output logic [rv_pkg::xlen-1:0] result,
  output logic                    branch_taken
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic eq;
  logic lt_signed;
  logic lt_unsigned;

  assign shamt = b[4:0];
  assign eq = (a == b);
  assign lt_signed = ($signed(a) < $signed(b));
  assign lt_unsigned = (a < b);

  always_comb begin
    case (alu_op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = $signed(a) >>> shamt;
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = a + b;
    endcase
  end

  always_comb begin
    case (branch_op)
      br_beq:  branch_taken = eq;
      br_bne:  branch_taken = !eq;
      br_blt:  branch_taken = lt_signed;
      br_bge:  branch_taken = !lt_signed;
      br_bltu: branch_taken = lt_unsigned;
      br_bgeu: branch_taken = !lt_unsigned;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== source/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  logic [rv_pkg::xlen-1:0] instr,
  output rv_pkg::decoded_t        dec
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_e f3_alu_op;
  logic op_funct7_ok;
  logic imm_funct7_ok;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct7 bit 5 selects sub/sra, but sub only exists for register operands
  always_comb begin
    case (funct3)
      3'b000:  f3_alu_op = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
      3'b001:  f3_alu_op = alu_sll;
      3'b010:  f3_alu_op = alu_slt;
      3'b011:  f3_alu_op = alu_sltu;
      3'b100:  f3_alu_op = alu_xor;
      3'b101:  f3_alu_op = funct7[5] ? alu_sra : alu_srl;
      3'b110:  f3_alu_op = alu_or;
      default: f3_alu_op = alu_and;
    endcase
  end

  assign op_funct7_ok = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  // only the shift immediates carry a funct7 field
  assign imm_funct7_ok = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                         (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) :
                         1'b1;

  always_comb begin
    dec = '0;
    dec.op_class  = cls_invalid;
    dec.alu_op    = f3_alu_op;
    dec.branch_op = br_beq;
    dec.mem_size  = mem_size_e'(funct3[1:0]);
    dec.load_unsigned = funct3[2];
    dec.rd  = instr[11:7];
    dec.rs1 = instr[19:15];
    dec.rs2 = instr[24:20];
    dec.imm = imm_i;
    case (opcode)
      opc_lui: begin
        dec.op_class = cls_lui;
        dec.imm = imm_u;
      end
      opc_auipc: begin
        dec.op_class = cls_auipc;
        dec.imm = imm_u;
      end
      opc_jal: begin
        dec.op_class = cls_jump;
        dec.imm = imm_j;
      end
      opc_jalr: begin
        if (funct3 == 3'b000) begin
          dec.op_class = cls_jump;
          dec.is_jalr = 1'b1;
        end
      end
      opc_branch: begin
        dec.imm = imm_b;
        dec.rd = '0;
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          dec.op_class = cls_branch;
          // funct3 1xx maps onto blt, bge, bltu, bgeu
          dec.branch_op = (funct3[2] == 1'b0) ? branch_op_e'({2'b00, funct3[0]}) :
                                                branch_op_e'({1'b0, funct3[1:0]} + 3'd2);
        end
      end
      opc_load: begin
        if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
          dec.op_class = cls_load;
        end
      end
      opc_store: begin
        dec.imm = imm_s;
        dec.rd = '0;
        if (funct3[2] == 1'b0 && funct3[1:0] != 2'b11) begin
          dec.op_class = cls_store;
        end
      end
      opc_op_imm: begin
        dec.use_imm = 1'b1;
        if (imm_funct7_ok) begin
          dec.op_class = cls_alu;
        end
      end
      opc_op: begin
        if (op_funct7_ok) begin
          dec.op_class = cls_alu;
        end
      end
      default: dec.op_class = cls_invalid;
    endcase
  end

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // major opcodes, instruction bits [6:0]
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;

  typedef enum logic [2:0] {
    cls_lui, cls_auipc, cls_jump, cls_branch, cls_load, cls_store, cls_alu, cls_invalid
  } op_class_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [2:0] {
    br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
  } branch_op_e;

  // encoded as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    mem_byte, mem_half, mem_word
  } mem_size_e;

  typedef struct packed {
    op_class_e             op_class;
    alu_op_e               alu_op;
    branch_op_e            branch_op;
    mem_size_e             mem_size;
    logic                  load_unsigned;
    logic                  use_imm;
    logic                  is_jalr;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
  } decoded_t;

  typedef struct packed {
    logic            valid;
    logic            instr;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0]      wstrb;
  } mem_req_t;

  typedef enum logic [3:0] {
    st_fetch, st_wait_fetch, st_decode, st_execute, st_wait_load,
    st_wait_store, st_check_pc, st_write_back, st_trapped
  } cpu_state_e;

endpackage
